// ==== src.f ====
hdl/conv_pkg.sv
hdl/conv_axil_slave.sv
hdl/conv_regfile.sv
hdl/conv_job_sequencer.sv
hdl/conv_job_fifo.sv
hdl/conv_accel_top.sv
dv/conv_accel_checker.sv
dv/conv_accel_tb.sv

// ==== dv/conv_accel_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_accel_tb import conv_pkg::*; ();

	localparam int CLK_NS      = 8;
	localparam int N_ACCESS    = 60;
	localparam int N_JOBS      = 12;
	localparam int ITEM_CYCLES = 32;
	localparam int WATCHDOG_NS = (N_ACCESS + N_JOBS) * ITEM_CYCLES * CLK_NS + 16 * CLK_NS;

	// Layer used by the job tests
	localparam logic [15:0] D_WID  = 16'd28;
	localparam logic [15:0] D_HEI  = 16'd20;
	localparam logic [15:0] D_CH   = 16'd3;
	localparam logic [15:0] F_WID  = 16'd3;
	localparam logic [15:0] F_HEI  = 16'd3;
	localparam logic [15:0] F_OUT  = 16'd2;
	localparam logic [7:0]  STRIDE = 8'd2;
	localparam logic [31:0] D_BASE = 32'h1000_4000;
	localparam logic [31:0] F_BASE = 32'h2000_0100;
	localparam logic [31:0] O_BASE = 32'h3000_8000;

	localparam logic [13:0] RW_IDX [13] = '{DATA_WID_IDX, DATA_HEI_IDX, DATA_CH_IDX,
		FILTER_WID_IDX, FILTER_HEI_IDX, FILTER_OUT_CH_IDX, STRIDE_VERT_IDX,
		DATA_LOAD_MSB_IDX, DATA_LOAD_LSB_IDX, FILTER_LOAD_MSB_IDX, FILTER_LOAD_LSB_IDX,
		OUTPUT_SAVE_MSB_IDX, OUTPUT_SAVE_LSB_IDX};
	// Upper halves carry junk that the DUT drops
	localparam logic [31:0] RW_VAL [13] = '{{16'hA5A5, D_WID}, {16'h5A5A, D_HEI},
		{16'h0000, D_CH}, {16'hFFFF, F_WID}, {16'h1234, F_HEI}, {16'h0000, F_OUT},
		{16'h0000, 8'h34, STRIDE}, {16'h0000, D_BASE[31:16]}, {16'h0000, D_BASE[15:0]},
		{16'h0000, F_BASE[31:16]}, {16'h0000, F_BASE[15:0]},
		{16'h0000, O_BASE[31:16]}, {16'h0000, O_BASE[15:0]}};

	logic        clk;
	logic        rst;
	logic [15:0] awaddr;
	logic        awvalid;
	logic        awready;
	logic [31:0] wdata;
	logic        wvalid;
	logic        wready;
	logic        bvalid;
	logic        bready;
	logic [1:0]  bresp;
	logic [15:0] araddr;
	logic        arvalid;
	logic        arready;
	logic        rvalid;
	logic        rready;
	logic [31:0] rdata;
	logic [1:0]  rresp;
	logic        out_valid;
	logic        out_ready;
	conv_job_t   out_job;

	conv_job_t   exp_q[$];
	int          jobs_pending;
	int          errors;
	int          checks;
	int          test_mark;
	int          failing_tests;
	int          proto_seen;
	logic        random_ready;
	logic [31:0] rnd;

	conv_accel_top #(
		.FIFO_DEPTH (4)
	) i_conv_accel_top (
		.clk       (clk),
		.rst       (rst),
		.awaddr    (awaddr),
		.awvalid   (awvalid),
		.awready   (awready),
		.wdata     (wdata),
		.wvalid    (wvalid),
		.wready    (wready),
		.bvalid    (bvalid),
		.bready    (bready),
		.bresp     (bresp),
		.araddr    (araddr),
		.arvalid   (arvalid),
		.arready   (arready),
		.rvalid    (rvalid),
		.rready    (rready),
		.rdata     (rdata),
		.rresp     (rresp),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_job   (out_job)
	);

	always #(CLK_NS / 2) clk = ~clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	// All DUT state changes land in the NBA region, so values read right
	// after an edge are the ones the DUT saw at that edge
	task automatic write_reg(input logic [13:0] idx, input logic [31:0] val);
		@(posedge clk);
		awaddr  <= {idx, 2'b00};
		wdata   <= val;
		awvalid <= 1'b1;
		wvalid  <= 1'b1;
		do begin
			@(posedge clk);
		end while (!awready);
		check_value("wready", 32'h1, 32'(wready));
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		do begin
			@(posedge clk);
		end while (!bvalid);
		check_value("bresp", 32'h0, 32'(bresp));
	endtask

	task automatic read_reg(input logic [13:0] idx, output logic [31:0] val);
		@(posedge clk);
		araddr  <= {idx, 2'b00};
		arvalid <= 1'b1;
		do begin
			@(posedge clk);
		end while (!arready);
		arvalid <= 1'b0;
		do begin
			@(posedge clk);
		end while (!rvalid);
		val = rdata;
		check_value("rresp", 32'h0, 32'(rresp));
	endtask

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
		checks++;
		assert (got === exp) else begin
			$display("ERR %0t %s exp %h got %h", $time, name, exp, got);
			errors++;
		end
	endtask

	task automatic expect_reg(input logic [13:0] idx, input logic [31:0] exp);
		logic [31:0] got;
		read_reg(idx, got);
		check_value($sformatf("rdata reg 0x%03h", idx), exp, got);
	endtask

	// Readback around a write that must be ignored
	task automatic protect_check(input logic [13:0] idx, input logic [31:0] exp);
		expect_reg(idx, exp);
		write_reg(idx, 32'h0000_FFFE);
		expect_reg(idx, exp);
	endtask

	// Reference jobs from the address formulas with cin innermost
	task automatic load_expected();
		conv_job_t j;
		for (int co = 0; co < F_OUT; co++) begin
			for (int ci = 0; ci < D_CH; ci++) begin
				j.data_addr   = D_BASE + ci * D_WID * D_HEI;
				j.filter_addr = F_BASE + (co * D_CH + ci) * F_WID * F_HEI;
				j.out_addr    = O_BASE + co * D_WID * D_HEI;
				j.row_step    = STRIDE * D_WID;
				j.cin         = 12'(ci);
				j.cout        = 12'(co);
				exp_q.push_back(j);
				jobs_pending++;
			end
		end
	endtask

	task automatic end_test(input int num, input string name);
		int proto_now;
		// Protocol assertion failures from the bound checker count as errors
		proto_now  = i_conv_accel_top.i_conv_accel_checker.fail_count;
		errors    += proto_now - proto_seen;
		proto_seen = proto_now;
		if (errors == test_mark) begin
			$display("test %0d %s: ok", num, name);
		end else begin
			$display("test %0d %s: FAILED with %0d errors", num, name, errors - test_mark);
			failing_tests++;
		end
		test_mark = errors;
	endtask

	// Response back-pressure runs through every test
	always @(posedge clk) begin
		rnd       <= xorshift32(rnd);
		out_ready <= random_ready ? rnd[7] : 1'b1;
		bready    <= rnd[13];
		rready    <= rnd[21];
	end

	// Job monitor comparing in order against the reference list
	always @(posedge clk) begin
		if (!rst && out_valid && out_ready) begin
			if (exp_q.size() == 0) begin
				$display("Unexpected job at %0t with no reference job left", $time);
				errors++;
			end else begin
				checks++;
				assert (out_job === exp_q[0]) else begin
					$display("ERR %0t out_job exp %h got %h", $time, exp_q[0], out_job);
					errors++;
				end
				void'(exp_q.pop_front());
				jobs_pending--;
			end
		end
	end

	a_no_stray_job: assert property (@(posedge clk) disable iff (rst)
		out_valid |-> jobs_pending != 0)
		else begin
			$display("ERR %0t out_valid exp 0 got 1", $time);
			errors++;
		end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, a handshake never completed", WATCHDOG_NS);
		$display("tests failed");
		$finish;
	end

	initial begin
		logic [31:0] exp_word;
		clk          = 1'b0;
		rst          = 1'b1;
		awaddr       = '0;
		awvalid      = 1'b0;
		wdata        = '0;
		wvalid       = 1'b0;
		bready       = 1'b1;
		araddr       = '0;
		arvalid      = 1'b0;
		rready       = 1'b1;
		out_ready    = 1'b1;
		random_ready = 1'b0;
		rnd          = 32'd6759;
		jobs_pending = 0;
		errors       = 0;
		checks       = 0;
		test_mark    = 0;
		proto_seen   = 0;
		failing_tests = 0;
		repeat (8) @(posedge clk);
		rst <= 1'b0;

		for (int i = 0; i < 13; i++) begin
			write_reg(RW_IDX[i], RW_VAL[i]);
		end
		for (int i = 0; i < 13; i++) begin
			if (RW_IDX[i] == STRIDE_VERT_IDX) begin
				exp_word = {24'h000000, RW_VAL[i][7:0]};
			end else begin
				exp_word = {16'h0000, RW_VAL[i][15:0]};
			end
			expect_reg(RW_IDX[i], exp_word);
		end
		end_test(1, "register readback");

		// Control goes first so the status reads below also show no start
		protect_check(CTRL_IDX, 32'h0);
		protect_check(FILTER_CH_IDX, 32'h0);
		protect_check(DATA_STATUS_CIN_IDX, 32'h0);
		protect_check(DATA_STATUS_COUT_IDX, 32'h0);
		protect_check(STATUS_IDX, 32'h1 << STAT_IDLE);
		expect_reg(14'h200, 32'h0);
		expect_reg(14'h100, 32'h0);
		end_test(2, "protected and unmapped registers");

		load_expected();
		write_reg(CTRL_IDX, 32'h1);
		wait (jobs_pending == 0);
		end_test(3, "job order and contents");

		random_ready = 1'b1;
		load_expected();
		write_reg(CTRL_IDX, 32'h1);
		wait (jobs_pending == 0);
		random_ready = 1'b0;
		end_test(4, "back-pressure");

		expect_reg(STATUS_IDX, (32'h1 << STAT_IDLE) | (32'h1 << STAT_DONE));
		expect_reg(FILTER_CH_IDX, 32'(D_CH * F_OUT));
		expect_reg(DATA_STATUS_CIN_IDX, 32'(D_CH - 16'd1));
		expect_reg(DATA_STATUS_COUT_IDX, 32'(F_OUT - 16'd1));
		end_test(5, "status after a run");

		write_reg(DATA_CH_IDX, 32'h0);
		write_reg(CTRL_IDX, 32'h1);
		expect_reg(STATUS_IDX, (32'h1 << STAT_IDLE) | (32'h1 << STAT_ERR));
		// Give a stray job time to show up
		repeat (20) @(posedge clk);
		end_test(6, "zero-channel error");

		$display("summary: 6 tests run, %0d failing, %0d checks, %0d errors",
			failing_tests, checks, errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== dv/conv_accel_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_accel_checker import conv_pkg::*; #(
	parameter int FIFO_DEPTH = 4
) (
	input wire logic        clk,
	input wire logic        rst,
	input wire logic        awready,
	input wire logic        wready,
	input wire logic        arready,
	input wire logic        bvalid,
	input wire logic        bready,
	input wire logic        rvalid,
	input wire logic        rready,
	input wire logic [31:0] rdata,
	input wire logic        job_valid,
	input wire logic        job_ready,
	input wire logic        out_valid,
	input wire logic        out_ready,
	input wire conv_job_t   out_job
);

	logic [7:0] occupancy;
	logic       push;
	logic       pop;
	int         fail_count = 0;

	assign push = job_valid && job_ready;
	assign pop  = out_valid && out_ready;

	// Fill level of the job FIFO as seen through its two handshakes
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			occupancy <= '0;
		end else begin
			occupancy <= occupancy + 8'(push) - 8'(pop);
		end
	end

	a_bvalid_hold: assert property (@(posedge clk) disable iff (rst)
		bvalid && !bready |=> bvalid)
		else begin
			$error("bvalid dropped before bready");
			fail_count++;
		end

	a_rvalid_hold: assert property (@(posedge clk) disable iff (rst)
		rvalid && !rready |=> rvalid && $stable(rdata))
		else begin
			$error("rvalid or rdata changed before rready");
			fail_count++;
		end

	a_out_stable: assert property (@(posedge clk) disable iff (rst)
		out_valid && !out_ready |=> out_valid && $stable(out_job))
		else begin
			$error("out_job not held under back-pressure");
			fail_count++;
		end

	a_reset_quiet: assert property (@(posedge clk)
		rst |-> !(bvalid || rvalid || awready || wready || arready || job_valid || out_valid))
		else begin
			$error("handshake output high during reset");
			fail_count++;
		end

	// A push into a full FIFO needs the head to leave in the same cycle
	a_no_overflow: assert property (@(posedge clk) disable iff (rst)
		push && (occupancy == FIFO_DEPTH) |-> pop)
		else begin
			$error("job pushed into a full FIFO");
			fail_count++;
		end

	a_fill_bound: assert property (@(posedge clk) disable iff (rst)
		occupancy <= FIFO_DEPTH)
		else begin
			$error("FIFO fill level above its depth");
			fail_count++;
		end

endmodule

bind conv_accel_top conv_accel_checker #(
	.FIFO_DEPTH (FIFO_DEPTH)
) i_conv_accel_checker (
	.clk       (clk),
	.rst       (rst),
	.awready   (awready),
	.wready    (wready),
	.arready   (arready),
	.bvalid    (bvalid),
	.bready    (bready),
	.rvalid    (rvalid),
	.rready    (rready),
	.rdata     (rdata),
	.job_valid (job_valid),
	.job_ready (job_ready),
	.out_valid (out_valid),
	.out_ready (out_ready),
	.out_job   (out_job)
);

`default_nettype wire

// ==== hdl/conv_accel_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_accel_top import conv_pkg::*; #(
	parameter int FIFO_DEPTH = 4
) (
	input  wire logic        clk,
	input  wire logic        rst,

	// AXI4-Lite configuration port
	input  wire logic [15:0] awaddr,
	input  wire logic        awvalid,
	output logic             awready,
	input  wire logic [31:0] wdata,
	input  wire logic        wvalid,
	output logic             wready,
	output logic             bvalid,
	input  wire logic        bready,
	output logic [1:0]       bresp,
	input  wire logic [15:0] araddr,
	input  wire logic        arvalid,
	output logic             arready,
	output logic             rvalid,
	input  wire logic        rready,
	output logic [31:0]      rdata,
	output logic [1:0]       rresp,

	// Job descriptor output
	output logic             out_valid,
	input  wire logic        out_ready,
	output conv_job_t        out_job
);

	logic        wr_en;
	logic        rd_en;
	logic [13:0] addr;
	logic [15:0] write_data;
	logic [15:0] read_data;
	conv_cfg_t   cfg;
	conv_stat_t  stat;
	logic        start;
	logic        job_valid;
	logic        job_ready;
	conv_job_t   job;

	conv_axil_slave i_conv_axil_slave (
		.clk        (clk),
		.rst        (rst),
		.awaddr     (awaddr),
		.awvalid    (awvalid),
		.awready    (awready),
		.wdata      (wdata),
		.wvalid     (wvalid),
		.wready     (wready),
		.bvalid     (bvalid),
		.bready     (bready),
		.bresp      (bresp),
		.araddr     (araddr),
		.arvalid    (arvalid),
		.arready    (arready),
		.rvalid     (rvalid),
		.rready     (rready),
		.rdata      (rdata),
		.rresp      (rresp),
		.wr_en      (wr_en),
		.rd_en      (rd_en),
		.addr       (addr),
		.write_data (write_data),
		.read_data  (read_data)
	);

	conv_regfile i_conv_regfile (
		.clk        (clk),
		.rst        (rst),
		.wr_en      (wr_en),
		.rd_en      (rd_en),
		.addr       (addr),
		.write_data (write_data),
		.read_data  (read_data),
		.stat       (stat),
		.cfg        (cfg),
		.start      (start)
	);

	conv_job_sequencer i_conv_job_sequencer (
		.clk       (clk),
		.rst       (rst),
		.cfg       (cfg),
		.start     (start),
		.job_ready (job_ready),
		.job_valid (job_valid),
		.job       (job),
		.stat      (stat)
	);

	conv_job_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) i_conv_job_fifo (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (job_valid),
		.in_ready  (job_ready),
		.in_job    (job),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_job   (out_job)
	);

endmodule

`default_nettype wire

// ==== hdl/conv_job_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_job_fifo import conv_pkg::*; #(
	parameter int FIFO_DEPTH = 4
) (
	input  wire logic       clk,
	input  wire logic       rst,
	input  wire logic       in_valid,
	output logic            in_ready,
	input  wire conv_job_t  in_job,
	output logic            out_valid,
	input  wire logic       out_ready,
	output conv_job_t       out_job
);

	localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CW = $clog2(FIFO_DEPTH + 1);

	conv_job_t       mem [FIFO_DEPTH];
	logic [AW-1:0]   wr_ptr;
	logic [AW-1:0]   rd_ptr;
	logic [CW-1:0]   count;
	logic            push;
	logic            pop;

	// A full FIFO still takes a job when the head leaves in the same cycle
	assign in_ready  = (count != CW'(FIFO_DEPTH)) || out_ready;
	assign out_valid = (count != '0);
	assign out_job   = mem[rd_ptr];

	assign push = in_valid && in_ready;
	assign pop  = out_valid && out_ready;

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= in_job;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hdl/conv_job_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_job_sequencer import conv_pkg::*; (
	input  wire logic       clk,
	input  wire logic       rst,
	input  wire conv_cfg_t  cfg,
	input  wire logic       start,
	input  wire logic       job_ready,
	output logic            job_valid,
	output conv_job_t       job,
	output conv_stat_t      stat
);

	logic        busy;
	logic        done;
	logic        err;
	logic [15:0] cin;
	logic [15:0] cout;
	logic [15:0] job_total;

	// Loop bounds and step sizes captured at start
	logic [15:0] n_cin;
	logic [15:0] n_cout;
	logic [31:0] plane_sz;
	logic [31:0] filt_sz;
	logic [31:0] data_base;

	logic last_cin;
	logic last_cout;
	logic xfer;

	assign last_cin  = (cin == n_cin - 16'd1);
	assign last_cout = (cout == n_cout - 16'd1);
	assign xfer      = busy && job_ready;

	// Control and counters
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			busy      <= 1'b0;
			done      <= 1'b0;
			err       <= 1'b0;
			cin       <= '0;
			cout      <= '0;
			job_total <= '0;
		end else if (start && !busy) begin
			done      <= 1'b0;
			cin       <= '0;
			cout      <= '0;
			job_total <= 16'(cfg.data_ch * cfg.filter_out_ch);
			if (cfg.data_ch == 16'd0 || cfg.filter_out_ch == 16'd0) begin
				err  <= 1'b1;
				busy <= 1'b0;
			end else begin
				err  <= 1'b0;
				busy <= 1'b1;
			end
		end else if (xfer) begin
			if (last_cin && last_cout) begin
				// Counters keep the final pair for readback
				busy <= 1'b0;
				done <= 1'b1;
			end else if (last_cin) begin
				cin  <= '0;
				cout <= cout + 16'd1;
			end else begin
				cin <= cin + 16'd1;
			end
		end
	end

	// Address accumulators, advanced once per transferred job
	always_ff @(posedge clk) begin
		if (start && !busy) begin
			n_cin            <= cfg.data_ch;
			n_cout           <= cfg.filter_out_ch;
			plane_sz         <= 32'(cfg.data_wid * cfg.data_hei);
			filt_sz          <= 32'(cfg.filter_wid * cfg.filter_hei);
			data_base        <= cfg.data_base;
			job.data_addr    <= cfg.data_base;
			job.filter_addr  <= cfg.filter_base;
			job.out_addr     <= cfg.out_base;
			job.row_step     <= 32'(cfg.stride_vert * cfg.data_wid);
		end else if (xfer) begin
			// Filters are stored back to back in job order
			job.filter_addr <= job.filter_addr + filt_sz;
			if (last_cin) begin
				job.data_addr <= data_base;
				job.out_addr  <= job.out_addr + plane_sz;
			end else begin
				job.data_addr <= job.data_addr + plane_sz;
			end
		end
	end

	assign job.cin   = cin[11:0];
	assign job.cout  = cout[11:0];
	assign job_valid = busy;

	assign stat.filter_ch         = job_total;
	assign stat.cur_cin           = cin;
	assign stat.cur_cout          = cout;
	assign stat.status[STAT_IDLE] = !busy;
	assign stat.status[STAT_BUSY] = busy;
	assign stat.status[STAT_DONE] = done;
	assign stat.status[STAT_ERR]  = err;

endmodule

`default_nettype wire

// ==== hdl/conv_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_regfile import conv_pkg::*; (
	input  wire logic        clk,
	input  wire logic        rst,
	input  wire logic        wr_en,
	input  wire logic        rd_en,
	input  wire logic [13:0] addr,
	input  wire logic [15:0] write_data,
	output logic [15:0]      read_data,
	input  wire conv_stat_t  stat,
	output conv_cfg_t        cfg,
	output logic             start
);

	conv_cfg_t   cfg_q;
	logic [15:0] rd_mux;

	assign cfg = cfg_q;

	// Read-write configuration registers
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			cfg_q <= '0;
		end else if (wr_en) begin
			case (addr)
				DATA_WID_IDX:        cfg_q.data_wid            <= write_data;
				DATA_HEI_IDX:        cfg_q.data_hei            <= write_data;
				DATA_CH_IDX:         cfg_q.data_ch             <= write_data;
				FILTER_WID_IDX:      cfg_q.filter_wid          <= write_data;
				FILTER_HEI_IDX:      cfg_q.filter_hei          <= write_data;
				FILTER_OUT_CH_IDX:   cfg_q.filter_out_ch       <= write_data;
				STRIDE_VERT_IDX:     cfg_q.stride_vert         <= write_data[7:0];
				DATA_LOAD_MSB_IDX:   cfg_q.data_base[31:16]    <= write_data;
				DATA_LOAD_LSB_IDX:   cfg_q.data_base[15:0]     <= write_data;
				FILTER_LOAD_MSB_IDX: cfg_q.filter_base[31:16]  <= write_data;
				FILTER_LOAD_LSB_IDX: cfg_q.filter_base[15:0]   <= write_data;
				OUTPUT_SAVE_MSB_IDX: cfg_q.out_base[31:16]     <= write_data;
				OUTPUT_SAVE_LSB_IDX: cfg_q.out_base[15:0]      <= write_data;
				// Read-only and control indices fall through here
				default: ;
			endcase
		end
	end

	// Start strobe, one cycle after the control write
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			start <= 1'b0;
		end else begin
			start <= wr_en && (addr == CTRL_IDX) && write_data[0];
		end
	end

	always_comb begin
		case (addr)
			DATA_WID_IDX:         rd_mux = cfg_q.data_wid;
			DATA_HEI_IDX:         rd_mux = cfg_q.data_hei;
			DATA_CH_IDX:          rd_mux = cfg_q.data_ch;
			FILTER_WID_IDX:       rd_mux = cfg_q.filter_wid;
			FILTER_HEI_IDX:       rd_mux = cfg_q.filter_hei;
			FILTER_CH_IDX:        rd_mux = stat.filter_ch;
			FILTER_OUT_CH_IDX:    rd_mux = cfg_q.filter_out_ch;
			STRIDE_VERT_IDX:      rd_mux = {8'h00, cfg_q.stride_vert};
			DATA_LOAD_MSB_IDX:    rd_mux = cfg_q.data_base[31:16];
			DATA_LOAD_LSB_IDX:    rd_mux = cfg_q.data_base[15:0];
			FILTER_LOAD_MSB_IDX:  rd_mux = cfg_q.filter_base[31:16];
			FILTER_LOAD_LSB_IDX:  rd_mux = cfg_q.filter_base[15:0];
			OUTPUT_SAVE_MSB_IDX:  rd_mux = cfg_q.out_base[31:16];
			OUTPUT_SAVE_LSB_IDX:  rd_mux = cfg_q.out_base[15:0];
			DATA_STATUS_CIN_IDX:  rd_mux = stat.cur_cin;
			DATA_STATUS_COUT_IDX: rd_mux = stat.cur_cout;
			STATUS_IDX:           rd_mux = {12'h000, stat.status};
			// Control register and unmapped space read zero
			default:              rd_mux = 16'h0000;
		endcase
	end

	// Keep the read bus quiet outside read cycles
	assign read_data = rd_en ? rd_mux : 16'h0000;

endmodule

`default_nettype wire

// ==== hdl/conv_axil_slave.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_axil_slave (
	input  wire logic        clk,
	input  wire logic        rst,

	// Write address and data
	input  wire logic [15:0] awaddr,
	input  wire logic        awvalid,
	output logic             awready,
	input  wire logic [31:0] wdata,
	input  wire logic        wvalid,
	output logic             wready,

	// Write response
	output logic             bvalid,
	input  wire logic        bready,
	output logic [1:0]       bresp,

	// Read address and data
	input  wire logic [15:0] araddr,
	input  wire logic        arvalid,
	output logic             arready,
	output logic             rvalid,
	input  wire logic        rready,
	output logic [31:0]      rdata,
	output logic [1:0]       rresp,

	// Register access port
	output logic             wr_en,
	output logic             rd_en,
	output logic [13:0]      addr,
	output logic [15:0]      write_data,
	input  wire logic [15:0] read_data
);

	logic wr_acc;
	logic rd_acc;

	// Address and data must arrive together, one outstanding response at a time
	assign wr_acc = awvalid && wvalid && !bvalid;

	// Write wins when both channels show up in the same cycle,
	// since both share the single register address
	assign rd_acc = arvalid && !rvalid && !wr_acc;

	assign awready = wr_acc;
	assign wready  = wr_acc;
	assign arready = rd_acc;

	assign wr_en      = wr_acc;
	assign rd_en      = rd_acc;
	assign addr       = wr_acc ? awaddr[15:2] : araddr[15:2];
	assign write_data = wdata[15:0];

	// Always OKAY
	assign bresp = 2'b00;
	assign rresp = 2'b00;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			bvalid <= 1'b0;
		end else if (wr_acc) begin
			bvalid <= 1'b1;
		end else if (bready) begin
			bvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rvalid <= 1'b0;
		end else if (rd_acc) begin
			rvalid <= 1'b1;
		end else if (rready) begin
			rvalid <= 1'b0;
		end
	end

	// Upper half of the read word is always zero
	always_ff @(posedge clk) begin
		if (rd_acc) begin
			rdata <= {16'h0000, read_data};
		end
	end

endmodule

`default_nettype wire

// ==== hdl/conv_pkg.sv ====
`default_nettype none

package conv_pkg;

	// Register indices, taken from byte address bits 15:2
	localparam logic [13:0] DATA_WID_IDX         = 14'h101;
	localparam logic [13:0] DATA_HEI_IDX         = 14'h102;
	localparam logic [13:0] DATA_CH_IDX          = 14'h103;
	localparam logic [13:0] FILTER_WID_IDX       = 14'h104;
	localparam logic [13:0] FILTER_HEI_IDX       = 14'h105;
	localparam logic [13:0] FILTER_CH_IDX        = 14'h106;
	localparam logic [13:0] FILTER_OUT_CH_IDX    = 14'h107;
	localparam logic [13:0] STRIDE_VERT_IDX      = 14'h108;
	localparam logic [13:0] DATA_LOAD_MSB_IDX    = 14'h109;
	localparam logic [13:0] DATA_LOAD_LSB_IDX    = 14'h10a;
	localparam logic [13:0] FILTER_LOAD_MSB_IDX  = 14'h10b;
	localparam logic [13:0] FILTER_LOAD_LSB_IDX  = 14'h10c;
	localparam logic [13:0] OUTPUT_SAVE_MSB_IDX  = 14'h10d;
	localparam logic [13:0] OUTPUT_SAVE_LSB_IDX  = 14'h10e;
	localparam logic [13:0] DATA_STATUS_CIN_IDX  = 14'h10f;
	localparam logic [13:0] DATA_STATUS_COUT_IDX = 14'h110;
	localparam logic [13:0] STATUS_IDX           = 14'h111;
	localparam logic [13:0] CTRL_IDX             = 14'h112;

	// Bit positions in the status nibble
	localparam int STAT_IDLE = 0;
	localparam int STAT_BUSY = 1;
	localparam int STAT_DONE = 2;
	localparam int STAT_ERR  = 3;

	typedef struct packed {
		logic [15:0] data_wid;
		logic [15:0] data_hei;
		logic [15:0] data_ch;
		logic [15:0] filter_wid;
		logic [15:0] filter_hei;
		logic [15:0] filter_out_ch;
		logic [7:0]  stride_vert;
		logic [31:0] data_base;
		logic [31:0] filter_base;
		logic [31:0] out_base;
	} conv_cfg_t;

	typedef struct packed {
		logic [15:0] filter_ch;
		logic [15:0] cur_cin;
		logic [15:0] cur_cout;
		logic [3:0]  status;
	} conv_stat_t;

	typedef struct packed {
		logic [31:0] data_addr;
		logic [31:0] filter_addr;
		logic [31:0] out_addr;
		logic [31:0] row_step;
		logic [11:0] cin;
		logic [11:0] cout;
	} conv_job_t;

endpackage

`default_nettype wire
